// File: project.f
+incdir+.
boot_pkg.sv
boot_sequencer.sv
load_fifo.sv
boot_store.sv
boot_loader.sv
boot_loader_assertions.sv
tb_boot_loader.sv

// File: run_sim.sh
#!/bin/sh
# build and run the boot loader testbench with Verilator
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_boot_loader \
    -f project.f > sim.log 2>&1 \
    && ./obj_dir/Vtb_boot_loader +verilator+error+limit+100 >> sim.log 2>&1

cat sim.log
grep -q "All tests passed!" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: tb_boot_loader.sv
/*
 * boot loader testbench
 *   clock, reset, start pulse
 *   host model for request and data channels with random gaps
 *   random outside reads during loading, read-back after run
 *   watchdog and end of run report
 */
`timescale 1ns/1ns
`default_nettype none
`include "boot_params.svh"

module tb_boot_loader;
    import boot_pkg::*;

    localparam int HOST_W     = `BOOT_HOST_ADDR_W;
    localparam int SEG_WORDS  = `BOOT_SEG_WORDS;
    localparam int DM_SEGS    = `BOOT_DM_SEGS;
    localparam int LOAD_SEGS  = `BOOT_DM_SEGS + `BOOT_IM_SEGS;
    localparam int LOAD_WORDS = SEG_WORDS * LOAD_SEGS;
    localparam int WATCHDOG_CYCLES = 40 * LOAD_WORDS + 2 * LOAD_WORDS + 20;

    logic                    clk;
    logic                    rst_n;
    logic                    start;
    logic                    req_valid;
    host_req_t               req;
    logic                    req_ready;
    logic                    data_valid;
    logic [`BOOT_DATA_W-1:0] data;
    logic                    data_ready;
    logic                    rd_en;
    mem_sel_e                rd_sel;
    logic [`BOOT_ADDR_W-1:0] rd_addr;
    logic [`BOOT_DATA_W-1:0] rd_data;
    logic                    run;

    logic [HOST_W-1:0] pending_addr[$];  // accepted requests with bursts still open
    int                word_idx   = 0;
    int                req_count  = 0;
    int                words_sent = 0;
    logic              started    = 1'b0;

    boot_loader DUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("Test failures found");
        $fatal(1, "run stopped at first error");
    endtask

    // host address of request r, by the segment rule
    function automatic logic [HOST_W-1:0] expected_req_addr(input int r);
        logic [HOST_W-1:0] a;
        if (r < DM_SEGS) begin
            a = HOST_W'(`BOOT_DM_BASE) + HOST_W'(r * `BOOT_SEG_BYTES);
        end else begin
            a = HOST_W'((r - DM_SEGS) * `BOOT_SEG_BYTES);
            a[`BOOT_IM_HOST_BIT] = 1'b1;
        end
        return a;
    endfunction

    function automatic logic [31:0] host_word(input logic [HOST_W-1:0] addr, input int i);
        logic [31:0] w;
        w = addr[31:0] + 32'(i * 4);
        if (addr[`BOOT_IM_HOST_BIT]) begin
            w = w ^ 32'h5a5a0000;  // instruction space pattern
        end
        return w;
    endfunction

    function automatic logic [31:0] expected_word(input mem_sel_e sel, input int k);
        int seg;
        seg = k / SEG_WORDS;
        if (sel == MEM_IM) begin
            seg = seg + DM_SEGS;
        end
        return host_word(expected_req_addr(seg), k % SEG_WORDS);
    endfunction

    ////////////////////
    // host model and read traffic on the falling edge

    always @(negedge clk) begin
        req_ready = req_valid && (($urandom % 4) != 0);
        if (pending_addr.size() != 0) begin
            data_valid = ($urandom % 3) != 0;
            data       = host_word(pending_addr[0], word_idx);
        end else begin
            data_valid = 1'b0;
            data       = '0;
        end
        if (started && !run) begin  // steal the memory port now and then
            rd_en   = ($urandom % 4) == 0;
            rd_sel  = (($urandom % 2) == 0) ? MEM_DM : MEM_IM;
            rd_addr = 16'($urandom);
        end
        if (DUT.u_chk.fail_count != 0) begin
            stop_with_failure("a protocol assertion in the bound checker failed");
        end
    end

    // handshakes seen at the rising edge
    always @(posedge clk) begin
        if (run) begin
            assert (words_sent == LOAD_WORDS) else stop_with_failure($sformatf(
                "[FAIL] %0t ns: run high after %0d of %0d words", $time, words_sent, LOAD_WORDS));
        end
        if (rst_n && req_valid && req_ready) begin
            assert (req_count < LOAD_SEGS) else stop_with_failure($sformatf(
                "[FAIL] %0t ns: request after the last segment", $time));
            assert (req.op == READ && req.addr == expected_req_addr(req_count))
                else stop_with_failure($sformatf("[FAIL] %0t ns: request %0d op %0d addr %h",
                    $time, req_count, req.op, req.addr));
            pending_addr.push_back(req.addr);
            req_count++;
        end
        if (rst_n && data_valid && data_ready) begin
            words_sent++;
            if (word_idx == SEG_WORDS - 1) begin
                word_idx = 0;
                void'(pending_addr.pop_front());
            end else begin
                word_idx++;
            end
        end
    end

    task automatic read_back(input mem_sel_e sel, input int words);
        logic [`BOOT_ADDR_W-1:0] base;
        logic [31:0]             want;
        base = (sel == MEM_DM) ? `BOOT_DM_BASE : '0;
        for (int k = 0; k < words; k++) begin
            rd_en   = 1'b1;
            rd_sel  = sel;
            rd_addr = base + 16'(k * 4);
            @(negedge clk);  // rd_data one cycle later
            want = expected_word(sel, k);
            assert (rd_data == want) else stop_with_failure($sformatf(
                "[FAIL] %0t ns: mem %0d word %0d read %h, expected %h",
                $time, sel, k, rd_data, want));
        end
        rd_en = 1'b0;
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_with_failure("timeout: the loader did not finish within the watchdog limit");
    end

    ////////////////////
    // main sequence

    initial begin
        void'($urandom(32'h8b3c));
        rst_n      = 1'b0;
        start      = 1'b0;
        req_ready  = 1'b0;
        data_valid = 1'b0;
        data       = '0;
        rd_en      = 1'b0;
        rd_sel     = MEM_DM;
        rd_addr    = '0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        start   = 1'b1;
        started <= 1'b1;
        @(negedge clk);
        start = 1'b0;
        wait (run);
        @(negedge clk);
        assert (req_count == LOAD_SEGS) else stop_with_failure($sformatf(
            "[FAIL] %0t ns: %0d requests seen, expected %0d", $time, req_count, LOAD_SEGS));
        read_back(MEM_DM, SEG_WORDS * `BOOT_DM_SEGS);
        read_back(MEM_IM, SEG_WORDS * `BOOT_IM_SEGS);
        if (DUT.u_chk.fail_count != 0) begin
            stop_with_failure("a protocol assertion in the bound checker failed");
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: boot_loader_assertions.sv
/*
 * boot loader protocol checker
 *   outputs low in and right after reset
 *   host request held while stalled
 *   run sticky, no requests after run
 */
`timescale 1ns/1ns
`default_nettype none

module boot_loader_assertions (
    input logic                clk,
    input logic                rst_n,
    input logic                req_valid,
    input boot_pkg::host_req_t req,
    input logic                req_ready,
    input logic                data_ready,
    input logic                run
);

    int fail_count = 0;  // watched by the testbench

    reset_outputs_low: assert property (@(posedge clk)
        (!rst_n || $rose(rst_n)) |-> (!req_valid && !data_ready && !run))
    else begin
        fail_count = fail_count + 1;
        $error("req_valid, data_ready or run high around reset");
    end

    ////////////////////
    // request channel

    req_held_while_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        (req_valid && !req_ready) |=> (req_valid && $stable(req)))
    else begin
        fail_count = fail_count + 1;
        $error("host request changed while stalled");
    end

    ////////////////////
    // run flag

    run_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        run |=> run)
    else begin
        fail_count = fail_count + 1;
        $error("run fell before reset");
    end

    no_req_after_run: assert property (@(posedge clk) disable iff (!rst_n)
        run |-> !req_valid)
    else begin
        fail_count = fail_count + 1;
        $error("host request raised after run");
    end

endmodule

bind boot_loader boot_loader_assertions u_chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .req        (req),
    .req_ready  (req_ready),
    .data_ready (data_ready),
    .run        (run)
);

`default_nettype wire

// File: boot_loader.sv
/*
 * boot loader top level
 *   sequencer -> load FIFO -> store
 */
`timescale 1ns/1ns
`default_nettype none
`include "boot_params.svh"

module boot_loader (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    output logic                    req_valid,
    output boot_pkg::host_req_t     req,
    input  logic                    req_ready,
    input  logic                    data_valid,
    input  logic [`BOOT_DATA_W-1:0] data,
    output logic                    data_ready,
    input  logic                    rd_en,
    input  boot_pkg::mem_sel_e      rd_sel,
    input  logic [`BOOT_ADDR_W-1:0] rd_addr,
    output logic [`BOOT_DATA_W-1:0] rd_data,
    output logic                    run
);
    import boot_pkg::*;

    load_word_t seq_word;   // sequencer to FIFO
    logic       seq_valid;
    logic       seq_ready;
    load_word_t fifo_word;  // FIFO to store
    logic       fifo_valid;
    logic       fifo_ready;

    boot_sequencer u_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .data_valid (data_valid),
        .data       (data),
        .data_ready (data_ready),
        .out_valid  (seq_valid),
        .out_word   (seq_word),
        .out_ready  (seq_ready)
    );

    load_fifo u_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (seq_valid),
        .in_word   (seq_word),
        .in_ready  (seq_ready),
        .out_valid (fifo_valid),
        .out_word  (fifo_word),
        .out_ready (fifo_ready)
    );

    boot_store u_store (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (fifo_valid),
        .in_word  (fifo_word),
        .in_ready (fifo_ready),
        .rd_en    (rd_en),
        .rd_sel   (rd_sel),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .run      (run)
    );

endmodule

`default_nettype wire

// File: boot_store.sv
/*
 * boot store
 *   data and instruction memories, single port each
 *   load write path, outside read port with priority
 *   run flag, set once the last word is written
 */
`timescale 1ns/1ns
`default_nettype none
`include "boot_params.svh"

module boot_store (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  boot_pkg::load_word_t    in_word,
    output logic                    in_ready,
    input  logic                    rd_en,
    input  boot_pkg::mem_sel_e      rd_sel,
    input  logic [`BOOT_ADDR_W-1:0] rd_addr,
    output logic [`BOOT_DATA_W-1:0] rd_data,
    output logic                    run
);
    import boot_pkg::*;

    localparam int ADDR_W   = `BOOT_ADDR_W;
    localparam int DM_WORDS = `BOOT_SEG_WORDS * `BOOT_DM_SEGS;
    localparam int IM_WORDS = `BOOT_SEG_WORDS * `BOOT_IM_SEGS;
    localparam int DM_IDX_W = $clog2(DM_WORDS);
    localparam int IM_IDX_W = $clog2(IM_WORDS);

    logic [`BOOT_DATA_W-1:0] dm_mem [DM_WORDS];
    logic [`BOOT_DATA_W-1:0] im_mem [IM_WORDS];

    logic              wr_fire;
    logic [ADDR_W-1:0] wr_off;
    logic [ADDR_W-1:0] rd_off;

    // byte offset from the start of the selected memory
    function automatic logic [ADDR_W-1:0] mem_offset(mem_sel_e sel, logic [ADDR_W-1:0] addr);
        logic [ADDR_W-1:0] base;
        base = (sel == MEM_DM) ? ADDR_W'(`BOOT_DM_BASE) : '0;
        return addr - base;
    endfunction

    assign in_ready = !rd_en;  // outside read owns the port
    assign wr_fire  = in_valid && in_ready;
    assign wr_off   = mem_offset(in_word.target, in_word.addr);
    assign rd_off   = mem_offset(rd_sel, rd_addr);

    ////////////////////
    // load writes

    always_ff @(posedge clk) begin
        if (wr_fire && in_word.target == MEM_DM) begin
            dm_mem[wr_off[DM_IDX_W+1:2]] <= in_word.data;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire && in_word.target == MEM_IM) begin
            im_mem[wr_off[IM_IDX_W+1:2]] <= in_word.data;
        end
    end

    ////////////////////
    // outside read, data one cycle after rd_en

    always_ff @(posedge clk) begin
        if (rd_en) begin
            if (rd_sel == MEM_DM) begin
                rd_data <= dm_mem[rd_off[DM_IDX_W+1:2]];
            end else begin
                rd_data <= im_mem[rd_off[IM_IDX_W+1:2]];
            end
        end
    end

    // sticky until reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run <= 1'b0;
        end else if (wr_fire && in_word.last) begin
            run <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: load_fifo.sv
/*
 * load FIFO
 *   circular buffer of tagged load words
 *   valid/ready on both sides, push and pop in one cycle
 */
`timescale 1ns/1ns
`default_nettype none
`include "boot_params.svh"

module load_fifo (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  boot_pkg::load_word_t in_word,
    output logic                 in_ready,
    output logic                 out_valid,
    output boot_pkg::load_word_t out_word,
    input  logic                 out_ready
);
    import boot_pkg::*;

    localparam int DEPTH = `BOOT_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    load_word_t       buf_mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign in_ready  = (count != CNT_W'(DEPTH));  // low only when full
    assign out_valid = (count != '0);
    assign out_word  = buf_mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            buf_mem[wr_ptr] <= in_word;
        end
    end

    // pointers wrap at depth
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (push && !pop) begin
            count <= count + 1'b1;
        end else if (pop && !push) begin
            count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: boot_sequencer.sv
/*
 * boot sequencer
 *   FSM over data segments then instruction segments
 *   one host READ request per segment, fixed length burst back
 *   words tagged with target memory, local byte address, last flag
 */
`timescale 1ns/1ns
`default_nettype none
`include "boot_params.svh"

module boot_sequencer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    output logic                    req_valid,
    output boot_pkg::host_req_t     req,
    input  logic                    req_ready,
    input  logic                    data_valid,
    input  logic [`BOOT_DATA_W-1:0] data,
    output logic                    data_ready,
    output logic                    out_valid,
    output boot_pkg::load_word_t    out_word,
    input  logic                    out_ready
);
    import boot_pkg::*;

    localparam int ADDR_W   = `BOOT_ADDR_W;
    localparam int HOST_W   = `BOOT_HOST_ADDR_W;
    localparam int MAX_SEGS = (`BOOT_DM_SEGS > `BOOT_IM_SEGS) ? `BOOT_DM_SEGS : `BOOT_IM_SEGS;
    localparam int SEG_W    = $clog2(MAX_SEGS + 1);
    localparam int WORD_W   = $clog2(`BOOT_SEG_WORDS);

    boot_state_e       state, state_nxt;
    mem_sel_e          target;    // memory being filled
    logic [SEG_W-1:0]  seg_cnt;   // segment within current memory
    logic [WORD_W-1:0] word_cnt;  // word within burst

    logic [ADDR_W-1:0] seg_base;
    logic [HOST_W-1:0] host_addr;
    logic              last_seg;
    logic              last_word;
    logic              word_fire;
    logic              seg_end;

    ////////////////////
    // segment address rule

    assign seg_base = ((target == MEM_DM) ? ADDR_W'(`BOOT_DM_BASE) : '0)
                    + ADDR_W'(seg_cnt) * ADDR_W'(`BOOT_SEG_BYTES);

    always_comb begin
        host_addr = HOST_W'(seg_base);
        if (target == MEM_IM) begin
            host_addr[`BOOT_IM_HOST_BIT] = 1'b1;  // instruction space
        end
    end

    assign last_seg  = (target == MEM_DM) ? (seg_cnt == SEG_W'(`BOOT_DM_SEGS - 1))
                                          : (seg_cnt == SEG_W'(`BOOT_IM_SEGS - 1));
    assign last_word = (word_cnt == WORD_W'(`BOOT_SEG_WORDS - 1));

    ////////////////////
    // host and FIFO handshakes

    assign req_valid  = (state == BOOT_REQ);
    assign req        = '{op: READ, addr: host_addr};  // held while in BOOT_REQ

    assign data_ready = (state == BOOT_DATA) && out_ready;  // FIFO room
    assign out_valid  = (state == BOOT_DATA) && data_valid;
    assign word_fire  = out_valid && out_ready;
    assign seg_end    = word_fire && last_word;

    assign out_word.target = target;
    assign out_word.addr   = seg_base + ADDR_W'({word_cnt, 2'b00});
    assign out_word.data   = data;
    assign out_word.last   = (target == MEM_IM) && last_seg && last_word;

    ////////////////////
    // FSM

    always_comb begin
        state_nxt = state;
        case (state)
            BOOT_IDLE: begin
                if (start) begin
                    state_nxt = BOOT_REQ;
                end
            end
            BOOT_REQ: begin
                if (req_ready) begin
                    state_nxt = BOOT_DATA;
                end
            end
            BOOT_DATA: begin
                if (seg_end) begin
                    // after final instruction segment, loading is over
                    state_nxt = (target == MEM_IM && last_seg) ? BOOT_DONE : BOOT_REQ;
                end
            end
            default: begin
                state_nxt = state;  // done until reset
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= BOOT_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // segment and word counters
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            target   <= MEM_DM;
            seg_cnt  <= '0;
            word_cnt <= '0;
        end else if (word_fire) begin
            word_cnt <= last_word ? '0 : word_cnt + 1'b1;
            if (last_word) begin
                if (!last_seg) begin
                    seg_cnt <= seg_cnt + 1'b1;
                end else if (target == MEM_DM) begin
                    target  <= MEM_IM;  // data done, on to instructions
                    seg_cnt <= '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: boot_pkg.sv
/*
 * boot loader types
 *   host opcode, target memory select, sequencer state
 *   host request and tagged load word structs
 */
`default_nettype none
`include "boot_params.svh"

package boot_pkg;

    // host side opcode, only READ is issued during boot
    typedef enum logic [1:0] {
        IDLE  = 2'b00,
        READ  = 2'b01,
        WRITE = 2'b11
    } host_op_e;

    typedef enum logic {
        MEM_DM = 1'b0,
        MEM_IM = 1'b1
    } mem_sel_e;

    typedef enum logic [1:0] {
        BOOT_IDLE,
        BOOT_REQ,   // request out to host
        BOOT_DATA,  // burst in progress
        BOOT_DONE
    } boot_state_e;

    typedef struct packed {
        host_op_e                     op;
        logic [`BOOT_HOST_ADDR_W-1:0] addr;
    } host_req_t;

    // word headed for local memory
    typedef struct packed {
        mem_sel_e                target;
        logic [`BOOT_ADDR_W-1:0] addr;   // local byte address
        logic [`BOOT_DATA_W-1:0] data;
        logic                    last;   // final word of final segment
    } load_word_t;

endpackage

`default_nettype wire

// File: boot_params.svh
/*
 * boot loader parameters
 *   word, local and host address widths
 *   burst length and segment span, segment counts
 *   data memory base address, instruction-space host flag
 *   load FIFO depth
 */
`ifndef BOOT_PARAMS_SVH
`define BOOT_PARAMS_SVH

////////////////////
// widths
`define BOOT_DATA_W       32
`define BOOT_ADDR_W       16
`define BOOT_HOST_ADDR_W  64

////////////////////
// segment layout
// one burst fills one segment
`define BOOT_SEG_WORDS    16
`define BOOT_SEG_BYTES    64
`define BOOT_DM_SEGS      4
`define BOOT_IM_SEGS      4

// local byte address of data segment 0
`define BOOT_DM_BASE      16'h1000
// set in host address for instruction fetches
`define BOOT_IM_HOST_BIT  16

// loader to store buffering
`define BOOT_FIFO_DEPTH   4

`endif
